/* llb_pkg.sv */
/*
  Shared sizes and the list action type for the multi-ID linked-list store.
  Compile this package before every other source file.
*/
package llb_pkg;

  // Message ID and number of per-ID lists
  localparam int unsigned IdWidth = 2;
  localparam int unsigned NumIds = 1 << IdWidth;

  // Shared slot pool
  localparam int unsigned Capacity = 16;
  localparam int unsigned AddrWidth = $clog2(Capacity);

  // Payload without the ID
  localparam int unsigned DataWidth = 16;

  // One extra bit so a full list of Capacity entries fits
  localparam int unsigned CountWidth = AddrWidth + 1;

  // What a list does in a given cycle
  typedef enum logic [1:0] {
    LIST_IDLE     = 2'b00,
    LIST_PUSH     = 2'b01,
    LIST_POP      = 2'b10,
    LIST_PUSH_POP = 2'b11
  } list_op_e;

endpackage

/* llb_slot_alloc.sv */
/*
  Slot allocator for the shared pool. Keeps one occupancy bit per slot,
  offers the lowest free slot and takes claims and releases each cycle.
*/
`timescale 1ns/1ps

module llb_slot_alloc (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          claim_i,
  input  logic                          release_i,
  input  logic [llb_pkg::AddrWidth-1:0] release_addr_i,
  output logic [llb_pkg::AddrWidth-1:0] free_addr_o,
  output logic                          has_free_o
);

  logic [llb_pkg::Capacity-1:0] occ_d;
  logic [llb_pkg::Capacity-1:0] occ_q;

  // Lowest clear bit wins, scanning down so the last hit is the smallest
  always_comb begin
    free_addr_o = '0;
    for (int i = llb_pkg::Capacity - 1; i >= 0; i--) begin
      if (!occ_q[i]) begin
        free_addr_o = i[llb_pkg::AddrWidth-1:0];
      end
    end
  end

  assign has_free_o = ~&occ_q;

  // The claimed slot is clear and the released one is set, so they never collide
  always_comb begin
    occ_d = occ_q;
    if (claim_i) begin
      occ_d[free_addr_o] = 1'b1;
    end
    if (release_i) begin
      occ_d[release_addr_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

  // The top must hold back input while the pool is full
  a_no_claim_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    claim_i |-> has_free_o
  ) else $error("slot claimed while pool is full");

  // A release always comes from a list head, which must hold a slot
  a_release_occupied: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    release_i |-> occ_q[release_addr_i]
  ) else $error("released slot %0d is not occupied", release_addr_i);

endmodule

/* llb_id_list.sv */
/*
  Linked-list controller for one message ID. Tracks head, tail and length,
  appends newly claimed slots and requests the tail link write on append.
*/
`timescale 1ns/1ps

module llb_id_list #(
  parameter int unsigned ListId = 0
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          in_fire_i,
  input  logic [llb_pkg::IdWidth-1:0]   in_id_i,
  input  logic [llb_pkg::AddrWidth-1:0] free_addr_i,
  input  logic                          pop_i,
  input  logic [llb_pkg::AddrWidth-1:0] next_addr_i,
  output logic                          nonempty_o,
  output logic [llb_pkg::AddrWidth-1:0] head_addr_o,
  output logic                          link_we_o,
  output logic [llb_pkg::AddrWidth-1:0] link_addr_o
);

  logic                           push;
  llb_pkg::list_op_e              op;
  logic [llb_pkg::AddrWidth-1:0]  head_d;
  logic [llb_pkg::AddrWidth-1:0]  head_q;
  logic [llb_pkg::AddrWidth-1:0]  tail_d;
  logic [llb_pkg::AddrWidth-1:0]  tail_q;
  logic [llb_pkg::CountWidth-1:0] len_d;
  logic [llb_pkg::CountWidth-1:0] len_q;
  logic                           single;

  // Input belongs to this list only when the ID matches
  assign push = in_fire_i && (in_id_i == ListId[llb_pkg::IdWidth-1:0]);
  assign single = (len_q == llb_pkg::CountWidth'(1));

  always_comb begin
    case ({pop_i, push})
      2'b01:   op = llb_pkg::LIST_PUSH;
      2'b10:   op = llb_pkg::LIST_POP;
      2'b11:   op = llb_pkg::LIST_PUSH_POP;
      default: op = llb_pkg::LIST_IDLE;
    endcase
  end

  always_comb begin
    head_d = head_q;
    tail_d = tail_q;
    len_d = len_q;
    link_we_o = 1'b0;
    case (op)
      llb_pkg::LIST_PUSH: begin
        tail_d = free_addr_i;
        len_d = len_q + 1'b1;
        if (nonempty_o) begin
          link_we_o = 1'b1;
        end else begin
          head_d = free_addr_i;
        end
      end
      llb_pkg::LIST_POP: begin
        head_d = next_addr_i;
        len_d = len_q - 1'b1;
      end
      llb_pkg::LIST_PUSH_POP: begin
        tail_d = free_addr_i;
        // The only element leaves, so the new one becomes head directly
        if (single) begin
          head_d = free_addr_i;
        end else begin
          head_d = next_addr_i;
          link_we_o = 1'b1;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '0;
      tail_q <= '0;
      len_q <= '0;
    end else begin
      head_q <= head_d;
      tail_q <= tail_d;
      len_q <= len_d;
    end
  end

  assign nonempty_o = (len_q != '0);
  assign head_addr_o = head_q;
  // Link the old tail to the slot being appended
  assign link_addr_o = tail_q;

  // The arbiter grants only nonempty lists
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> nonempty_o
  ) else $error("list %0d popped while empty", ListId);

endmodule

/* llb_storage.sv */
/*
  Payload and next-pointer arrays for the shared pool. Written at the claimed
  slot on input, read combinationally at the granted head.
*/
`timescale 1ns/1ps

module llb_storage (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          wr_en_i,
  input  logic [llb_pkg::AddrWidth-1:0] wr_addr_i,
  input  logic [llb_pkg::DataWidth-1:0] wr_data_i,
  input  logic [llb_pkg::NumIds-1:0]    link_we_i,
  input  logic [llb_pkg::AddrWidth-1:0] link_addr_i [llb_pkg::NumIds],
  input  logic [llb_pkg::AddrWidth-1:0] rd_addr_i,
  output logic [llb_pkg::DataWidth-1:0] rd_data_o,
  output logic [llb_pkg::AddrWidth-1:0] rd_next_o
);

  logic [llb_pkg::DataWidth-1:0] data_mem [llb_pkg::Capacity];
  logic [llb_pkg::AddrWidth-1:0] next_mem [llb_pkg::Capacity];

  logic                          link_we;
  logic [llb_pkg::AddrWidth-1:0] link_addr;

  // Only the list that receives the input links, so an AND-OR merge is enough
  always_comb begin
    link_addr = '0;
    for (int i = 0; i < llb_pkg::NumIds; i++) begin
      link_addr |= link_addr_i[i] & {llb_pkg::AddrWidth{link_we_i[i]}};
    end
  end

  assign link_we = |link_we_i;

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      data_mem[wr_addr_i] <= wr_data_i;
    end
  end

  // Old tail now points at the slot being filled
  always_ff @(posedge clk_i) begin
    if (link_we) begin
      next_mem[link_addr] <= wr_addr_i;
    end
  end

  assign rd_data_o = data_mem[rd_addr_i];
  assign rd_next_o = next_mem[rd_addr_i];

  a_single_link: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(link_we_i)
  ) else $error("more than one list links in the same cycle");

  // A link write always accompanies a payload write
  a_link_with_write: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    link_we |-> wr_en_i
  ) else $error("link write without payload write");

endmodule

/* llb_release_arb.sv */
/*
  Release arbiter. Grants the lowest nonempty ID, selects its head slot for
  the read and pops that list when the output handshake completes.
*/
`timescale 1ns/1ps

module llb_release_arb (
  input  logic [llb_pkg::NumIds-1:0]    nonempty_i,
  input  logic [llb_pkg::AddrWidth-1:0] head_addr_i [llb_pkg::NumIds],
  input  logic                          out_ready_i,
  output logic                          out_valid_o,
  output logic [llb_pkg::IdWidth-1:0]   out_id_o,
  output logic [llb_pkg::AddrWidth-1:0] grant_addr_o,
  output logic [llb_pkg::NumIds-1:0]    pop_o,
  output logic                          release_o
);

  logic [llb_pkg::IdWidth-1:0] grant_id;
  logic                        out_fire;

  // Scan down so the lowest nonempty ID is the final hit
  always_comb begin
    grant_id = '0;
    for (int i = llb_pkg::NumIds - 1; i >= 0; i--) begin
      if (nonempty_i[i]) begin
        grant_id = i[llb_pkg::IdWidth-1:0];
      end
    end
  end

  assign out_valid_o = |nonempty_i;
  assign out_id_o = grant_id;
  assign grant_addr_o = head_addr_i[grant_id];

  assign out_fire = out_valid_o && out_ready_i;
  assign release_o = out_fire;

  always_comb begin
    pop_o = '0;
    if (out_fire) begin
      pop_o[grant_id] = 1'b1;
    end
  end

endmodule

/* llb_top.sv */
/*
  Multi-ID message store on shared linked lists. Messages enter with an ID,
  keep FIFO order per ID and leave lowest ID first over valid/ready.
*/
`timescale 1ns/1ps

module llb_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          in_valid_i,
  input  logic [llb_pkg::IdWidth-1:0]   in_id_i,
  input  logic [llb_pkg::DataWidth-1:0] in_data_i,
  output logic                          in_ready_o,
  output logic                          out_valid_o,
  output logic [llb_pkg::IdWidth-1:0]   out_id_o,
  output logic [llb_pkg::DataWidth-1:0] out_data_o,
  input  logic                          out_ready_i
);

  logic                          in_fire;
  logic [llb_pkg::AddrWidth-1:0] free_addr;
  logic                          has_free;

  logic [llb_pkg::NumIds-1:0]    nonempty;
  logic [llb_pkg::AddrWidth-1:0] head_addr [llb_pkg::NumIds];
  logic [llb_pkg::NumIds-1:0]    link_we;
  logic [llb_pkg::AddrWidth-1:0] link_addr [llb_pkg::NumIds];
  logic [llb_pkg::NumIds-1:0]    pop;

  logic [llb_pkg::AddrWidth-1:0] grant_addr;
  logic [llb_pkg::AddrWidth-1:0] rd_next;
  logic                          release_slot;

  // Input is taken whenever a slot is free
  assign in_ready_o = has_free;
  assign in_fire = in_valid_i && has_free;

  llb_slot_alloc u_slot_alloc (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .claim_i        (in_fire),
    .release_i      (release_slot),
    .release_addr_i (grant_addr),
    .free_addr_o    (free_addr),
    .has_free_o     (has_free)
  );

  for (genvar g = 0; g < llb_pkg::NumIds; g++) begin : g_list
    llb_id_list #(
      .ListId (g)
    ) u_id_list (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .in_fire_i   (in_fire),
      .in_id_i     (in_id_i),
      .free_addr_i (free_addr),
      .pop_i       (pop[g]),
      .next_addr_i (rd_next),
      .nonempty_o  (nonempty[g]),
      .head_addr_o (head_addr[g]),
      .link_we_o   (link_we[g]),
      .link_addr_o (link_addr[g])
    );
  end

  llb_storage u_storage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_en_i     (in_fire),
    .wr_addr_i   (free_addr),
    .wr_data_i   (in_data_i),
    .link_we_i   (link_we),
    .link_addr_i (link_addr),
    .rd_addr_i   (grant_addr),
    .rd_data_o   (out_data_o),
    .rd_next_o   (rd_next)
  );

  // The granted head is both the read address and the slot to free
  llb_release_arb u_release_arb (
    .nonempty_i   (nonempty),
    .head_addr_i  (head_addr),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o),
    .out_id_o     (out_id_o),
    .grant_addr_o (grant_addr),
    .pop_o        (pop),
    .release_o    (release_slot)
  );

  // A message needs one edge in storage before it can leave
  a_stored_first: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(out_valid_o) |-> $past(in_fire)
  ) else $error("output became valid without a prior acceptance");

endmodule

/* llb_tb.sv */
/*
  Self-checking testbench for the linked-list message store. Applies a table
  of push and pop steps and compares every cycle against a queue model.
*/
`timescale 1ns/1ps

module llb_tb;

  typedef struct packed {
    llb_pkg::list_op_e             op;
    logic [llb_pkg::IdWidth-1:0]   id;
    logic [llb_pkg::DataWidth-1:0] data;
    int unsigned                   cycles;
    int                            exp_occ;
  } entry_t;

  localparam int unsigned ClkPeriod = 4;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned RandomEntries = 300;
  localparam int unsigned MsgWidth = llb_pkg::IdWidth + llb_pkg::DataWidth;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          in_valid_i;
  logic [llb_pkg::IdWidth-1:0]   in_id_i;
  logic [llb_pkg::DataWidth-1:0] in_data_i;
  logic                          in_ready_o;
  logic                          out_valid_o;
  logic [llb_pkg::IdWidth-1:0]   out_id_o;
  logic [llb_pkg::DataWidth-1:0] out_data_o;
  logic                          out_ready_i;

  entry_t               table_q[$];
  // Stored messages in arrival order, each as {id, data}
  logic [MsgWidth-1:0]  model_q[$];
  longint unsigned      watchdog_ns;

  llb_top u_llb_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_id_i     (in_id_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_id_o    (out_id_o),
    .out_data_o  (out_data_o),
    .out_ready_i (out_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic add_entry(input llb_pkg::list_op_e op, input int id,
                           input int unsigned cycles, input int exp_occ);
    entry_t e;
    e.op = op;
    e.id = id[llb_pkg::IdWidth-1:0];
    e.data = llb_pkg::DataWidth'($urandom());
    e.cycles = cycles;
    e.exp_occ = exp_occ;
    table_q.push_back(e);
  endtask

  // Lowest ID wins, and the oldest message of that ID comes first
  function automatic int head_index();
    int best;
    best = -1;
    for (int i = 0; i < model_q.size(); i++) begin
      if (best < 0 ||
          model_q[i][MsgWidth-1:llb_pkg::DataWidth] <
          model_q[best][MsgWidth-1:llb_pkg::DataWidth]) begin
        best = i;
      end
    end
    return best;
  endfunction

  task automatic check_outputs();
    int head;
    head = head_index();
    check_value("in_ready_o", 32'(in_ready_o),
                32'(model_q.size() < llb_pkg::Capacity));
    check_value("out_valid_o", 32'(out_valid_o), 32'(head >= 0));
    if (head >= 0) begin
      check_value("out_id_o", 32'(out_id_o),
                  32'(model_q[head][MsgWidth-1:llb_pkg::DataWidth]));
      check_value("out_data_o", 32'(out_data_o),
                  32'(model_q[head][llb_pkg::DataWidth-1:0]));
    end
  endtask

  // Applies the effect of the coming rising edge to the model
  task automatic update_model();
    int   head;
    logic accept;
    head = head_index();
    accept = in_valid_i && (model_q.size() < llb_pkg::Capacity);
    if (out_ready_i && head >= 0) begin
      model_q.delete(head);
    end
    if (accept) begin
      model_q.push_back({in_id_i, in_data_i});
    end
  endtask

  task automatic apply_entry(input entry_t e);
    for (int unsigned k = 0; k < e.cycles; k++) begin
      @(negedge clk_i);
      in_valid_i = (e.op == llb_pkg::LIST_PUSH) || (e.op == llb_pkg::LIST_PUSH_POP);
      in_id_i = e.id;
      in_data_i = e.data + k[llb_pkg::DataWidth-1:0];
      out_ready_i = (e.op == llb_pkg::LIST_POP) || (e.op == llb_pkg::LIST_PUSH_POP);
      check_outputs();
      update_model();
    end
    // Negative means the step is random and has no fixed fill level
    if (e.exp_occ >= 0) begin
      check_value("occupancy", 32'(model_q.size()), 32'(e.exp_occ));
    end
  endtask

  task automatic build_table();
    logic [1:0]        r;
    llb_pkg::list_op_e op;
    // Idle after reset, then one ID in order
    add_entry(llb_pkg::LIST_IDLE, 0, 2, 0);
    add_entry(llb_pkg::LIST_PUSH, 2, 4, 4);
    add_entry(llb_pkg::LIST_POP, 0, 4, 0);
    // Several IDs, drained lowest first
    add_entry(llb_pkg::LIST_PUSH, 3, 2, 2);
    add_entry(llb_pkg::LIST_PUSH, 1, 2, 4);
    add_entry(llb_pkg::LIST_PUSH, 0, 1, 5);
    add_entry(llb_pkg::LIST_POP, 0, 5, 0);
    // Fill the pool, push against a full pool, then free one slot
    add_entry(llb_pkg::LIST_PUSH, 3, 8, 8);
    add_entry(llb_pkg::LIST_PUSH, 0, 8, 16);
    add_entry(llb_pkg::LIST_PUSH, 2, 3, 16);
    add_entry(llb_pkg::LIST_IDLE, 0, 2, 16);
    add_entry(llb_pkg::LIST_POP, 0, 1, 15);
    add_entry(llb_pkg::LIST_PUSH, 2, 1, 16);
    add_entry(llb_pkg::LIST_POP, 0, 16, 0);
    // Push and pop together on lists of length one and two
    add_entry(llb_pkg::LIST_PUSH, 0, 1, 1);
    add_entry(llb_pkg::LIST_PUSH_POP, 0, 3, 1);
    add_entry(llb_pkg::LIST_POP, 0, 1, 0);
    add_entry(llb_pkg::LIST_PUSH, 1, 2, 2);
    add_entry(llb_pkg::LIST_PUSH_POP, 1, 4, 2);
    add_entry(llb_pkg::LIST_PUSH, 2, 1, 3);
    add_entry(llb_pkg::LIST_PUSH_POP, 2, 2, 3);
    add_entry(llb_pkg::LIST_POP, 0, 3, 0);
    // Long mixed sequence for slot reuse
    for (int i = 0; i < RandomEntries; i++) begin
      r = 2'($urandom_range(3, 0));
      op = llb_pkg::list_op_e'(r);
      add_entry(op, int'($urandom_range(3, 0)), $urandom_range(3, 1), -1);
    end
  endtask

  initial begin
    int unsigned total;
    void'($urandom(32'hc60d_f067));
    rst_ni = 1'b0;
    in_valid_i = 1'b0;
    in_id_i = '0;
    in_data_i = '0;
    out_ready_i = 1'b0;
    build_table();
    total = ResetCycles;
    foreach (table_q[i]) begin
      total += table_q[i].cycles;
    end
    // Fifty spare cycles cover reset release and the final check
    watchdog_ns = longint'(total + 50) * ClkPeriod;
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (table_q[i]) begin
      apply_entry(table_q[i]);
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
    out_ready_i = 1'b0;
    check_outputs();
    $display(">>> PASS");
    $finish;
  end

  initial begin
    wait (watchdog_ns != 0);
    #(watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

/* vlog.f */
llb_pkg.sv
llb_slot_alloc.sv
llb_id_list.sv
llb_storage.sv
llb_release_arb.sv
llb_top.sv
llb_tb.sv

/* Makefile */
# Verilator build and run for the multi-ID linked-list store

VERILATOR ?= verilator
TOP       ?= llb_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= >>> PASS

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
